// ==== project.f ====
hdl/ndn_link_pkg.sv
hdl/pkt_queue.sv
hdl/pkt_serializer.sv
hdl/pkt_deserializer.sv
hdl/ndn_link_top.sv
testbench/ndn_link_asserts.sv
testbench/ndn_link_tb.sv

// ==== testbench/ndn_link_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module ndn_link_tb;
    import ndn_link_pkg::*;

    localparam int data_bits   = 256;
    localparam int queue_depth = 4;
    localparam int rst_cycles  = 5;
    // Start bit, meta and prefix
    localparam int head_cycles = 1 + meta_bits + prefix_bits;
    localparam int n_stim      = 14;
    // Rows from here on run after the mid-frame reset
    localparam int split_idx   = 12;

    // One row per push, gap is idle cycles before it
    typedef struct packed {
        pkt_type_e   kind;
        logic [5:0]  plen;
        logic [11:0] gap;
    } stim_t;

    stim_t stim [n_stim];

    logic                   clk;
    logic                   rst;
    logic                   tx_valid;
    logic [meta_bits-1:0]   tx_meta;
    logic [prefix_bits-1:0] tx_prefix;
    logic [data_bits-1:0]   tx_data;
    logic                   tx_full;
    logic                   mosi;
    logic                   miso;
    logic                   rx_valid;
    logic [meta_bits-1:0]   rx_meta;
    logic [prefix_bits-1:0] rx_prefix;
    logic [data_bits-1:0]   rx_data;

    // Packets the queue accepted, oldest first
    logic [meta_bits-1:0]   exp_meta   [$];
    logic [prefix_bits-1:0] exp_prefix [$];
    logic [data_bits-1:0]   exp_data   [$];

    logic [31:0] lcg_state;
    int          err_value;
    int          err_other;
    int          rx_count;
    int          drops;

    // Line loopback
    assign miso = mosi;

    always #10 clk = ~clk;

    ndn_link_top #(
        .data_bits   (data_bits),
        .queue_depth (queue_depth)
    ) u_dut (
        .clk       (clk),
        .rst       (rst),
        .tx_valid  (tx_valid),
        .tx_meta   (tx_meta),
        .tx_prefix (tx_prefix),
        .tx_data   (tx_data),
        .tx_full   (tx_full),
        .mosi      (mosi),
        .miso      (miso),
        .rx_valid  (rx_valid),
        .rx_meta   (rx_meta),
        .rx_prefix (rx_prefix),
        .rx_data   (rx_data)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic load_table();
        // Single interest, then a single data packet
        stim[0]  = '{pkt_interest, 6'd12, 12'd1};
        stim[1]  = '{pkt_data,     6'd40, 12'd400};
        // Mixed types back to back
        stim[2]  = '{pkt_interest, 6'd5,  12'd400};
        stim[3]  = '{pkt_data,     6'd21, 12'd0};
        stim[4]  = '{pkt_interest, 6'd63, 12'd0};
        stim[5]  = '{pkt_data,     6'd1,  12'd0};
        // Six in a row overrun the four slots
        stim[6]  = '{pkt_data,     6'd9,  12'd1000};
        stim[7]  = '{pkt_interest, 6'd30, 12'd0};
        stim[8]  = '{pkt_data,     6'd2,  12'd0};
        stim[9]  = '{pkt_data,     6'd48, 12'd0};
        stim[10] = '{pkt_interest, 6'd7,  12'd0};
        stim[11] = '{pkt_data,     6'd55, 12'd0};
        // After the second reset
        stim[12] = '{pkt_data,     6'd63, 12'd2};
        stim[13] = '{pkt_interest, 6'd0,  12'd0};
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            err_value++;
            $display("[ERROR] %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_meta(input logic [meta_bits-1:0] got,
                              input logic [meta_bits-1:0] exp);
        if (got !== exp) begin
            err_value++;
            $display("[ERROR] rx_meta: got 0x%h expected 0x%h", got, exp);
        end
    endtask

    task automatic check_prefix(input logic [prefix_bits-1:0] got,
                                input logic [prefix_bits-1:0] exp);
        if (got !== exp) begin
            err_value++;
            $display("[ERROR] rx_prefix: got 0x%h expected 0x%h", got, exp);
        end
    endtask

    task automatic check_data(input logic [data_bits-1:0] got,
                              input logic [data_bits-1:0] exp);
        if (got !== exp) begin
            err_value++;
            $display("[ERROR] rx_data: got 0x%h expected 0x%h", got, exp);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            tx_valid <= 1'b0;
        end
    endtask

    task automatic send_packet(input pkt_type_e kind, input logic [5:0] plen, input bit keep);
        logic [meta_bits-1:0]   meta;
        logic [prefix_bits-1:0] prefix;
        logic [data_bits-1:0]   data;
        logic [31:0]            rnd;
        int                     w;
        rnd            = lcg_next();
        // Bit 7 random, bit 6 type, low bits prefix length
        meta           = {rnd[16], 1'b0, plen};
        meta[type_bit] = kind;
        prefix         = {lcg_next(), lcg_next()};
        for (w = 0; w < data_bits / 32; w++) begin
            data[w*32 +: 32] = lcg_next();
        end
        @(posedge clk);
        tx_valid  <= 1'b1;
        tx_meta   <= meta;
        tx_prefix <= prefix;
        tx_data   <= data;
        // Queue takes the push on the next edge, full is settled here
        @(negedge clk);
        if (tx_full) begin
            drops++;
        end else if (keep) begin
            exp_meta.push_back(meta);
            exp_prefix.push_back(prefix);
            // Interest frames stop after the prefix
            if (kind == pkt_interest) begin
                exp_data.push_back({data_bits{1'b0}});
            end else begin
                exp_data.push_back(data);
            end
        end
    endtask

    task automatic receive_packet();
        rx_count++;
        if (exp_meta.size() == 0) begin
            err_other++;
            $display("Received a packet while none was outstanding, prefix 0x%h", rx_prefix);
        end else begin
            check_meta(rx_meta, exp_meta.pop_front());
            check_prefix(rx_prefix, exp_prefix.pop_front());
            check_data(rx_data, exp_data.pop_front());
        end
    endtask

    task automatic apply_reset(input int cycles);
        @(posedge clk);
        rst      <= 1'b1;
        tx_valid <= 1'b0;
        repeat (cycles) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_meta.size() != 0) begin
            @(posedge clk);
        end
        idle_cycles(4);
    endtask

    task automatic check_idle_outputs();
        @(negedge clk);
        check_bit("mosi", mosi, 1'b1);
        check_bit("rx_valid", rx_valid, 1'b0);
        check_bit("tx_full", tx_full, 1'b0);
    endtask

    // Registered outputs, sampled away from the rising edge
    always @(negedge clk) begin
        if (!rst && rx_valid) begin
            receive_packet();
        end
    end

    initial begin : watchdog
        int limit;
        int i;
        @(negedge rst);
        limit = 0;
        for (i = 0; i < n_stim; i++) begin
            limit += int'(stim[i].gap) + head_cycles + data_bits + 4;
        end
        // Frame cut by the second reset
        limit += head_cycles + data_bits + 4 + 2 * rst_cycles;
        limit *= 2;
        repeat (limit) @(posedge clk);
        $display("Timeout after %0d cycles with %0d packets still outstanding",
                 limit, exp_meta.size());
        $display("Received %0d, value errors %0d, other errors %0d",
                 rx_count, err_value, err_other + 1);
        $display("Simulation failed");
        $finish;
    end

    initial begin : main
        int i;
        int assert_fails;
        clk       = 1'b0;
        rst       = 1'b1;
        tx_valid  = 1'b0;
        tx_meta   = '0;
        tx_prefix = '0;
        tx_data   = '0;
        lcg_state = 32'h2b9d_72dd;
        err_value = 0;
        err_other = 0;
        rx_count  = 0;
        drops     = 0;
        load_table();
        apply_reset(rst_cycles);
        check_idle_outputs();

        for (i = 0; i < split_idx; i++) begin
            idle_cycles(int'(stim[i].gap));
            send_packet(stim[i].kind, stim[i].plen, 1'b1);
        end
        idle_cycles(1);
        wait_drain();
        if (drops == 0) begin
            err_other++;
            $display("Queue never reported full during the six packet burst");
        end

        // Data frame cut short by a reset once it is on the line
        send_packet(pkt_data, 6'd17, 1'b0);
        idle_cycles(1);
        while (mosi) @(negedge clk);
        idle_cycles(20);
        apply_reset(rst_cycles);
        check_idle_outputs();

        for (i = split_idx; i < n_stim; i++) begin
            idle_cycles(int'(stim[i].gap));
            send_packet(stim[i].kind, stim[i].plen, 1'b1);
        end
        idle_cycles(1);
        wait_drain();

        assert_fails = u_dut.u_asserts.fail_count;
        $display("Received %0d, value errors %0d, other errors %0d, assertion failures %0d",
                 rx_count, err_value, err_other, assert_fails);
        if (err_value + err_other + assert_fails == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/ndn_link_asserts.sv ====
`timescale 1ns/100ps
`default_nettype none

module ndn_link_asserts (
    input wire logic                     clk,
    input wire logic                     rst,
    input wire logic                     rx_valid,
    input wire logic                     mosi,
    input wire logic                     q_pop,
    input wire ndn_link_pkg::ser_state_e ser_state
);
    import ndn_link_pkg::*;

    // Running total of failed properties
    int fail_count = 0;

    // Received packet strobe lasts a single cycle
    rx_pulse: assert property (@(posedge clk) disable iff (rst) rx_valid |=> !rx_valid)
        else begin
            fail_count++;
            $error("rx_valid held high for two consecutive cycles");
        end

    // Receiver completes a frame only once the sender is back in idle
    // Frame lengths on both ends of the loopback must agree
    frame_align: assert property (@(posedge clk) disable iff (rst)
        rx_valid |-> (ser_state == ser_idle))
        else begin
            fail_count++;
            $error("rx_valid raised while the serializer is still sending");
        end

    // Every pop puts a start bit on the line one cycle later
    pop_start: assert property (@(posedge clk) disable iff (rst) q_pop |=> !mosi)
        else begin
            fail_count++;
            $error("no start bit on mosi in the cycle after a pop");
        end

endmodule

bind ndn_link_top ndn_link_asserts u_asserts (
    .clk       (clk),
    .rst       (rst),
    .rx_valid  (rx_valid),
    .mosi      (mosi),
    .q_pop     (q_pop),
    .ser_state (u_ser.state)
);

`default_nettype wire

// ==== hdl/ndn_link_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module ndn_link_top #(
    parameter int data_bits   = 256,
    parameter int queue_depth = 4
) (
    input  wire logic                               clk,
    input  wire logic                               rst,

    // Transmit request, a one cycle strobe with its packet
    input  wire logic                               tx_valid,
    input  wire logic [ndn_link_pkg::meta_bits-1:0]   tx_meta,
    input  wire logic [ndn_link_pkg::prefix_bits-1:0] tx_prefix,
    input  wire logic [data_bits-1:0]               tx_data,
    output logic                                    tx_full,

    // Serial line pins
    output logic                                    mosi,
    input  wire logic                               miso,

    // Received packet
    output logic                                    rx_valid,
    output logic      [ndn_link_pkg::meta_bits-1:0]   rx_meta,
    output logic      [ndn_link_pkg::prefix_bits-1:0] rx_prefix,
    output logic      [data_bits-1:0]               rx_data
);
    import ndn_link_pkg::*;

    // Queue head towards the serializer
    logic                   q_empty;
    logic                   q_pop;
    logic [meta_bits-1:0]   q_meta;
    logic [prefix_bits-1:0] q_prefix;
    logic [data_bits-1:0]   q_data;

    // Packet buffer, drops pushes when full
    pkt_queue #(
        .data_bits   (data_bits),
        .queue_depth (queue_depth)
    ) u_queue (
        .clk         (clk),
        .rst         (rst),
        .push        (tx_valid),
        .push_meta   (tx_meta),
        .push_prefix (tx_prefix),
        .push_data   (tx_data),
        .pop         (q_pop),
        .head_meta   (q_meta),
        .head_prefix (q_prefix),
        .head_data   (q_data),
        .empty       (q_empty),
        .full        (tx_full)
    );

    // Transmit side of the line
    pkt_serializer #(
        .data_bits (data_bits)
    ) u_ser (
        .clk      (clk),
        .rst      (rst),
        .q_empty  (q_empty),
        .q_meta   (q_meta),
        .q_prefix (q_prefix),
        .q_data   (q_data),
        .q_pop    (q_pop),
        .mosi     (mosi)
    );

    // Receive side, independent of the transmit path
    pkt_deserializer #(
        .data_bits (data_bits)
    ) u_des (
        .clk       (clk),
        .rst       (rst),
        .miso      (miso),
        .rx_valid  (rx_valid),
        .rx_meta   (rx_meta),
        .rx_prefix (rx_prefix),
        .rx_data   (rx_data)
    );

endmodule

`default_nettype wire

// ==== hdl/pkt_deserializer.sv ====
`timescale 1ns/100ps
`default_nettype none

module pkt_deserializer #(
    parameter int data_bits = 256
) (
    input  wire logic                               clk,
    input  wire logic                               rst,
    input  wire logic                               miso,
    output logic                                    rx_valid,
    output logic      [ndn_link_pkg::meta_bits-1:0]   rx_meta,
    output logic      [ndn_link_pkg::prefix_bits-1:0] rx_prefix,
    output logic      [data_bits-1:0]               rx_data
);
    import ndn_link_pkg::*;

    localparam int data_cnt_w = (data_bits > 1) ? $clog2(data_bits) : 1;

    des_state_e state;

    // Remaining bits in the current field
    logic [2:0]            meta_cnt;
    logic [5:0]            prefix_cnt;
    logic [data_cnt_w-1:0] data_cnt;

    // Type flag of the frame being received
    // Only read after the whole meta byte is in
    pkt_type_e rx_type;

    assign rx_type = pkt_type_e'(rx_meta[type_bit]);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= des_idle;
            meta_cnt   <= '0;
            prefix_cnt <= '0;
            data_cnt   <= '0;
            rx_valid   <= 1'b0;
            rx_meta    <= '0;
            rx_prefix  <= '0;
            rx_data    <= '0;
        end else begin
            // Single cycle strobe by default
            rx_valid <= 1'b0;

            case (state)
                des_idle: begin
                    // Low sample on an idle line is a start bit
                    if (!miso) begin
                        meta_cnt  <= 3'(meta_bits - 1);
                        rx_meta   <= '0;
                        rx_prefix <= '0;
                        // Interest frames leave this at zero
                        rx_data   <= '0;
                        state     <= des_meta;
                    end
                end
                des_meta: begin
                    // Bit 7 is a don't care but it is kept as sent
                    rx_meta  <= {rx_meta[meta_bits-2:0], miso};
                    meta_cnt <= meta_cnt - 1'b1;
                    if (meta_cnt == '0) begin
                        prefix_cnt <= 6'(prefix_bits - 1);
                        state      <= des_prefix;
                    end
                end
                des_prefix: begin
                    rx_prefix  <= {rx_prefix[prefix_bits-2:0], miso};
                    prefix_cnt <= prefix_cnt - 1'b1;
                    if (prefix_cnt == '0) begin
                        if (rx_type == pkt_interest) begin
                            rx_valid <= 1'b1;
                            state    <= des_idle;
                        end else begin
                            data_cnt <= data_cnt_w'(data_bits - 1);
                            state    <= des_data;
                        end
                    end
                end
                des_data: begin
                    rx_data  <= {rx_data[data_bits-2:0], miso};
                    data_cnt <= data_cnt - 1'b1;
                    if (data_cnt == '0) begin
                        rx_valid <= 1'b1;
                        state    <= des_idle;
                    end
                end
                default: state <= des_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/pkt_serializer.sv ====
`timescale 1ns/100ps
`default_nettype none

module pkt_serializer #(
    parameter int data_bits = 256
) (
    input  wire logic                               clk,
    input  wire logic                               rst,
    input  wire logic                               q_empty,
    input  wire logic [ndn_link_pkg::meta_bits-1:0]   q_meta,
    input  wire logic [ndn_link_pkg::prefix_bits-1:0] q_prefix,
    input  wire logic [data_bits-1:0]               q_data,
    output logic                                    q_pop,
    output logic                                    mosi
);
    import ndn_link_pkg::*;

    localparam int data_cnt_w = (data_bits > 1) ? $clog2(data_bits) : 1;

    ser_state_e state;

    // Bit counters, one per field, count down to zero
    logic [2:0]            meta_cnt;
    logic [5:0]            prefix_cnt;
    logic [data_cnt_w-1:0] data_cnt;

    // Shadow copy of the popped packet, shifted left as bits go out
    logic [meta_bits-1:0]   sh_meta;
    logic [prefix_bits-1:0] sh_prefix;
    logic [data_bits-1:0]   sh_data;
    pkt_type_e              sh_type;

    // Pop only from idle, so there is always one high cycle between frames
    assign q_pop = (state == ser_idle) && !q_empty;

    // Line driver, high when idle and low for the start bit
    always_comb begin
        case (state)
            ser_idle:   mosi = 1'b1;
            ser_start:  mosi = 1'b0;
            ser_meta:   mosi = sh_meta[meta_bits-1];
            ser_prefix: mosi = sh_prefix[prefix_bits-1];
            ser_data:   mosi = sh_data[data_bits-1];
            default:    mosi = 1'b1;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= ser_idle;
            meta_cnt   <= '0;
            prefix_cnt <= '0;
            data_cnt   <= '0;
        end else begin
            case (state)
                ser_idle: begin
                    if (q_pop) begin
                        state <= ser_start;
                    end
                end
                ser_start: begin
                    meta_cnt <= 3'(meta_bits - 1);
                    state    <= ser_meta;
                end
                ser_meta: begin
                    meta_cnt <= meta_cnt - 1'b1;
                    if (meta_cnt == '0) begin
                        prefix_cnt <= 6'(prefix_bits - 1);
                        state      <= ser_prefix;
                    end
                end
                ser_prefix: begin
                    prefix_cnt <= prefix_cnt - 1'b1;
                    if (prefix_cnt == '0) begin
                        // Interest frames end with the prefix
                        if (sh_type == pkt_data) begin
                            data_cnt <= data_cnt_w'(data_bits - 1);
                            state    <= ser_data;
                        end else begin
                            state <= ser_idle;
                        end
                    end
                end
                ser_data: begin
                    data_cnt <= data_cnt - 1'b1;
                    if (data_cnt == '0) begin
                        state <= ser_idle;
                    end
                end
                default: state <= ser_idle;
            endcase
        end
    end

    // Latch the queue head on the pop edge, then shift the active field
    always_ff @(posedge clk) begin
        if (q_pop) begin
            sh_meta   <= q_meta;
            sh_prefix <= q_prefix;
            sh_data   <= q_data;
            sh_type   <= pkt_type_e'(q_meta[type_bit]);
        end else begin
            case (state)
                ser_meta:   sh_meta   <= sh_meta << 1;
                ser_prefix: sh_prefix <= sh_prefix << 1;
                ser_data:   sh_data   <= sh_data << 1;
                default:    sh_meta   <= sh_meta;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/pkt_queue.sv ====
`timescale 1ns/100ps
`default_nettype none

module pkt_queue #(
    parameter int data_bits   = 256,
    parameter int queue_depth = 4
) (
    input  wire logic                               clk,
    input  wire logic                               rst,
    input  wire logic                               push,
    input  wire logic [ndn_link_pkg::meta_bits-1:0]   push_meta,
    input  wire logic [ndn_link_pkg::prefix_bits-1:0] push_prefix,
    input  wire logic [data_bits-1:0]               push_data,
    input  wire logic                               pop,
    output logic      [ndn_link_pkg::meta_bits-1:0]   head_meta,
    output logic      [ndn_link_pkg::prefix_bits-1:0] head_prefix,
    output logic      [data_bits-1:0]               head_data,
    output logic                                    empty,
    output logic                                    full
);
    import ndn_link_pkg::*;

    // Pointer and occupancy widths, depth need not be a power of two
    localparam int ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1;
    localparam int cnt_w = $clog2(queue_depth + 1);
    localparam logic [ptr_w-1:0] last_slot = ptr_w'(queue_depth - 1);
    localparam logic [cnt_w-1:0] depth_cnt = cnt_w'(queue_depth);

    // One slot holds a whole packet
    logic [meta_bits-1:0]   meta_mem   [queue_depth];
    logic [prefix_bits-1:0] prefix_mem [queue_depth];
    logic [data_bits-1:0]   data_mem   [queue_depth];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;

    logic do_push;
    logic do_pop;

    // Overflowing pushes are dropped here and nowhere else
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Levels come straight from the occupancy register
    assign empty = (count == '0);
    assign full  = (count == depth_cnt);

    // First word fall through, head visible without a read strobe
    assign head_meta   = meta_mem[rd_ptr];
    assign head_prefix = prefix_mem[rd_ptr];
    assign head_data   = data_mem[rd_ptr];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves the count alone
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Packet storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            meta_mem[wr_ptr]   <= push_meta;
            prefix_mem[wr_ptr] <= push_prefix;
            data_mem[wr_ptr]   <= push_data;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/ndn_link_pkg.sv ====
`default_nettype none

package ndn_link_pkg;

    // Frame field widths, MSB of each field goes on the line first
    localparam int meta_bits   = 8;
    localparam int prefix_bits = 64;

    // Position of the packet type flag inside the meta byte
    localparam int type_bit = 6;

    // Meta bit 6 selects the packet kind
    // Interest frames stop after the prefix, data frames carry a data field
    typedef enum logic {
        pkt_data     = 1'b0,
        pkt_interest = 1'b1
    } pkt_type_e;

    // Transmit side states
    typedef enum logic [2:0] {
        ser_idle,
        ser_start,
        ser_meta,
        ser_prefix,
        ser_data
    } ser_state_e;

    // Receive side states
    // No separate start state, the start bit is consumed in des_idle
    typedef enum logic [1:0] {
        des_idle,
        des_meta,
        des_prefix,
        des_data
    } des_state_e;

endpackage

`default_nettype wire
